// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  localparam int LINE_WIDTH   = 128;  // bits per line
  localparam int LINE_BYTES   = 16;
  localparam int CACHE_LINES  = 64;   // 1 KiB direct mapped
  localparam int MEM_BLOCKS   = 1024; // 16 KiB backing store

  // physical address split: {tag, index, offset}
  localparam int OFFSET_W     = 4;
  localparam int INDEX_W      = 6;
  localparam int BLOCK_ADDR_W = 10;   // tag + index
  localparam int TAG_W        = 4;    // addr bits above 13 ignored

  //////////////////////////////////////////////////////////////////////
  // memory model timing
  //////////////////////////////////////////////////////////////////////

  localparam int MEM_LATENCY  = 4;    // enable rise to ready pulse

  // store width as seen from the core
  typedef enum logic [1:0] {
    SZ_BYTE   = 2'd0,
    SZ_HALF   = 2'd1,
    SZ_WORD   = 2'd2,
    SZ_DOUBLE = 2'd3
  } store_size_e;

  // miss handling states
  typedef enum logic [1:0] {
    ST_IDLE       = 2'd0,
    ST_WRITE_BACK = 2'd1,
    ST_ALLOCATE   = 2'd2,
    ST_FILL       = 2'd3
  } ctrl_state_e;

endpackage

// ==== rtl/dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [dcache_pkg::INDEX_W-1:0] i_index,
  input  logic [dcache_pkg::TAG_W-1:0]   i_tag,
  input  logic                           i_replace_tag,
  input  logic                           i_set_dirty,
  input  logic                           i_clear_dirty,
  output logic                           o_hit,
  output logic                           o_dirty,
  output logic [dcache_pkg::TAG_W-1:0]   o_old_tag
);

  // tag storage, only meaningful where valid is set
  logic [dcache_pkg::TAG_W-1:0]     tag_mem [dcache_pkg::CACHE_LINES];
  logic [dcache_pkg::CACHE_LINES-1:0] valid_q;
  logic [dcache_pkg::CACHE_LINES-1:0] dirty_q;

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  assign o_old_tag = tag_mem[i_index];  // victim tag for write-back address
  assign o_dirty   = dirty_q[i_index];
  assign o_hit     = valid_q[i_index] && (o_old_tag == i_tag);

  //////////////////////////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_replace_tag) begin
      tag_mem[i_index] <= i_tag;
    end
  end

  // valid and dirty per line
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (i_replace_tag) begin
        valid_q[i_index] <= 1'b1;  // fresh line from memory
        dirty_q[i_index] <= 1'b0;
      end else if (i_set_dirty) begin
        dirty_q[i_index] <= 1'b1;  // store hit
      end else if (i_clear_dirty) begin
        dirty_q[i_index] <= 1'b0;  // write-back done
      end
    end
  end

endmodule

// ==== rtl/dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
  input  logic                              i_clk,
  input  logic                              i_wren,
  input  logic                              i_fill,
  input  logic [dcache_pkg::INDEX_W-1:0]    i_index,
  input  logic [dcache_pkg::OFFSET_W-1:0]   i_offset,
  input  dcache_pkg::store_size_e           i_store_size,
  input  logic [dcache_pkg::LINE_WIDTH-1:0] i_data,
  output logic [dcache_pkg::LINE_WIDTH-1:0] o_line
);

  logic [dcache_pkg::LINE_WIDTH-1:0] line_mem [dcache_pkg::CACHE_LINES];

  logic [dcache_pkg::LINE_BYTES-1:0] byte_en;     // bytes touched by the store
  logic [dcache_pkg::LINE_WIDTH-1:0] shifted_data;
  logic [dcache_pkg::LINE_WIDTH-1:0] merged_line;

  assign o_line = line_mem[i_index];  // async read

  //////////////////////////////////////////////////////////////////////
  // store merge
  //////////////////////////////////////////////////////////////////////

  // offset is assumed naturally aligned for the size
  always_comb begin
    case (i_store_size)
      dcache_pkg::SZ_BYTE:   byte_en = 16'h0001 << i_offset;
      dcache_pkg::SZ_HALF:   byte_en = 16'h0003 << i_offset;
      dcache_pkg::SZ_WORD:   byte_en = 16'h000f << i_offset;
      dcache_pkg::SZ_DOUBLE: byte_en = 16'h00ff << i_offset;
      default:               byte_en = '0;
    endcase
  end

  // move the low bytes of the store data up to the offset
  assign shifted_data = i_data << {i_offset, 3'b000};

  always_comb begin
    merged_line = o_line;
    for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
      if (byte_en[b]) begin
        merged_line[b*8 +: 8] = shifted_data[b*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_wren) begin
      if (i_fill) begin
        line_mem[i_index] <= i_data;       // whole block from memory
      end else begin
        line_mem[i_index] <= merged_line;  // partial store
      end
    end
  end

endmodule

// ==== rtl/dcache_ctrl_fsm.sv ====
`timescale 1ns/1ps

module dcache_ctrl_fsm (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_cpu_rden,
  input  logic i_cpu_wren,
  input  logic i_hit,
  input  logic i_dirty,
  input  logic i_mem_ready,
  output logic o_cache_wren,
  output logic o_fill,
  output logic o_mem_rden,
  output logic o_mem_wren,
  output logic o_tag_sel,
  output logic o_replace_tag,
  output logic o_set_dirty,
  output logic o_stall
);

  dcache_pkg::ctrl_state_e state_q;
  dcache_pkg::ctrl_state_e state_d;

  logic cpu_req;

  assign cpu_req = i_cpu_rden | i_cpu_wren;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= dcache_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    o_cache_wren  = 1'b0;
    o_fill        = 1'b0;
    o_mem_rden    = 1'b0;
    o_mem_wren    = 1'b0;
    o_tag_sel     = 1'b0;
    o_replace_tag = 1'b0;
    o_set_dirty   = 1'b0;
    o_stall       = 1'b0;

    case (state_q)
      dcache_pkg::ST_IDLE: begin
        if (cpu_req) begin
          if (i_hit) begin
            // hit load needs nothing, the line is already on the read port
            if (i_cpu_wren) begin
              o_cache_wren = 1'b1;
              o_set_dirty  = 1'b1;
            end
          end else begin
            o_stall = 1'b1;  // same-cycle stall on miss
            if (i_dirty) begin
              state_d = dcache_pkg::ST_WRITE_BACK;
            end else begin
              state_d = dcache_pkg::ST_ALLOCATE;
            end
          end
        end
      end

      // push the victim out under its old tag
      dcache_pkg::ST_WRITE_BACK: begin
        o_stall    = 1'b1;
        o_mem_wren = 1'b1;
        o_tag_sel  = 1'b1;
        if (i_mem_ready) begin
          state_d = dcache_pkg::ST_ALLOCATE;
        end
      end

      dcache_pkg::ST_ALLOCATE: begin
        o_stall    = 1'b1;
        o_mem_rden = 1'b1;  // held until ready
        if (i_mem_ready) begin
          state_d = dcache_pkg::ST_FILL;
        end
      end

      // block still on the memory read data, addr unchanged
      dcache_pkg::ST_FILL: begin
        o_stall       = 1'b1;
        o_cache_wren  = 1'b1;
        o_fill        = 1'b1;
        o_replace_tag = 1'b1;
        state_d       = dcache_pkg::ST_IDLE;  // held request hits next cycle
      end

      default: begin
        state_d = dcache_pkg::ST_IDLE;
      end
    endcase
  end

endmodule

// ==== rtl/dcache_backing_mem.sv ====
`timescale 1ns/1ps

module dcache_backing_mem (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_rden,
  input  logic                                i_wren,
  input  logic [dcache_pkg::BLOCK_ADDR_W-1:0] i_addr,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_data,
  output logic [dcache_pkg::LINE_WIDTH-1:0]   o_data,
  output logic                                o_ready
);

  localparam int CNT_W = $clog2(dcache_pkg::MEM_LATENCY + 1);

  logic [dcache_pkg::LINE_WIDTH-1:0] mem [dcache_pkg::MEM_BLOCKS];

  logic             access;
  logic [CNT_W-1:0] lat_cnt;

  // whole memory reads back as zero until written
  initial begin
    for (int i = 0; i < dcache_pkg::MEM_BLOCKS; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latency counter
  //////////////////////////////////////////////////////////////////////

  assign access  = i_rden | i_wren;
  assign o_ready = access && (lat_cnt == CNT_W'(dcache_pkg::MEM_LATENCY - 1));

  // back to zero between accesses and after each ready pulse
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lat_cnt <= '0;
    end else if (!access || o_ready) begin
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // block storage
  //////////////////////////////////////////////////////////////////////

  assign o_data = mem[i_addr];  // valid at the ready pulse

  always_ff @(posedge i_clk) begin
    if (i_wren && o_ready) begin
      mem[i_addr] <= i_data;  // write lands with ready
    end
  end

endmodule

// ==== rtl/riscv_data_cache.sv ====
`timescale 1ns/1ps

module riscv_data_cache (
  input  logic                    i_riscv_dcache_clk,
  input  logic                    i_rst_n,
  input  logic                    i_riscv_dcache_cpu_wren,
  input  logic                    i_riscv_dcache_cpu_rden,
  input  dcache_pkg::store_size_e i_riscv_dcache_store_src,
  input  logic [63:0]             i_riscv_dcache_phys_addr,
  input  logic [63:0]             i_riscv_dcache_cpu_data_in,
  output logic [63:0]             o_riscv_dcache_cpu_data_out,
  output logic                    o_riscv_dcache_cpu_stall
);

  //////////////////////////////////////////////////////////////////////
  // internal signals
  //////////////////////////////////////////////////////////////////////

  // address fields
  logic [dcache_pkg::TAG_W-1:0]        req_tag;
  logic [dcache_pkg::INDEX_W-1:0]      req_index;
  logic [dcache_pkg::OFFSET_W-1:0]     req_offset;

  // tag array
  logic                                tag_hit;
  logic                                tag_dirty;
  logic [dcache_pkg::TAG_W-1:0]        tag_old;

  // controller
  logic                                fsm_cache_wren;
  logic                                fsm_fill;
  logic                                fsm_mem_rden;
  logic                                fsm_mem_wren;
  logic                                fsm_tag_sel;
  logic                                fsm_replace_tag;
  logic                                fsm_set_dirty;

  // data paths
  logic                                mem_ready;
  logic                                wb_done;
  logic [dcache_pkg::BLOCK_ADDR_W-1:0] mem_addr;
  logic [dcache_pkg::LINE_WIDTH-1:0]   mem_rdata;
  logic [dcache_pkg::LINE_WIDTH-1:0]   cache_data_in;
  logic [dcache_pkg::LINE_WIDTH-1:0]   cache_line;

  assign req_offset = i_riscv_dcache_phys_addr[dcache_pkg::OFFSET_W-1:0];
  assign req_index  = i_riscv_dcache_phys_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
  assign req_tag    = i_riscv_dcache_phys_addr[dcache_pkg::OFFSET_W + dcache_pkg::INDEX_W +:
                                               dcache_pkg::TAG_W];

  // victim block address during write-back
  assign mem_addr = fsm_tag_sel ? {tag_old, req_index} : {req_tag, req_index};

  assign cache_data_in = fsm_fill ? mem_rdata :
                         {{(dcache_pkg::LINE_WIDTH - 64){1'b0}}, i_riscv_dcache_cpu_data_in};

  assign wb_done = fsm_mem_wren & mem_ready;  // line is clean once memory has it

  // doubleword select by addr bit 3
  assign o_riscv_dcache_cpu_data_out = i_riscv_dcache_phys_addr[3] ?
                                       cache_line[dcache_pkg::LINE_WIDTH-1:64] :
                                       cache_line[63:0];

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  dcache_tag_array u_tag_array (
    .i_clk         (i_riscv_dcache_clk),
    .i_rst_n       (i_rst_n),
    .i_index       (req_index),
    .i_tag         (req_tag),
    .i_replace_tag (fsm_replace_tag),
    .i_set_dirty   (fsm_set_dirty),
    .i_clear_dirty (wb_done),
    .o_hit         (tag_hit),
    .o_dirty       (tag_dirty),
    .o_old_tag     (tag_old)
  );

  dcache_data_array u_data_array (
    .i_clk        (i_riscv_dcache_clk),
    .i_wren       (fsm_cache_wren),
    .i_fill       (fsm_fill),
    .i_index      (req_index),
    .i_offset     (req_offset),
    .i_store_size (i_riscv_dcache_store_src),
    .i_data       (cache_data_in),
    .o_line       (cache_line)
  );

  dcache_backing_mem u_backing_mem (
    .i_clk   (i_riscv_dcache_clk),
    .i_rst_n (i_rst_n),
    .i_rden  (fsm_mem_rden),
    .i_wren  (fsm_mem_wren),
    .i_addr  (mem_addr),
    .i_data  (cache_line),  // write-back source
    .o_data  (mem_rdata),
    .o_ready (mem_ready)
  );

  dcache_ctrl_fsm u_cache_fsm (
    .i_clk         (i_riscv_dcache_clk),
    .i_rst_n       (i_rst_n),
    .i_cpu_rden    (i_riscv_dcache_cpu_rden),
    .i_cpu_wren    (i_riscv_dcache_cpu_wren),
    .i_hit         (tag_hit),
    .i_dirty       (tag_dirty),
    .i_mem_ready   (mem_ready),
    .o_cache_wren  (fsm_cache_wren),
    .o_fill        (fsm_fill),
    .o_mem_rden    (fsm_mem_rden),
    .o_mem_wren    (fsm_mem_wren),
    .o_tag_sel     (fsm_tag_sel),
    .o_replace_tag (fsm_replace_tag),
    .o_set_dirty   (fsm_set_dirty),
    .o_stall       (o_riscv_dcache_cpu_stall)
  );

endmodule

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

  localparam int STALL_LIMIT = 200;  // cycles per request
  localparam int MEM_BYTES   = dcache_pkg::MEM_BLOCKS * dcache_pkg::LINE_BYTES;

  logic                    clk;
  logic                    rst_n;
  logic                    cpu_wren;
  logic                    cpu_rden;
  dcache_pkg::store_size_e store_size;
  logic [63:0]             phys_addr;
  logic [63:0]             cpu_wdata;
  logic [63:0]             cpu_rdata;
  logic                    cpu_stall;

  logic [7:0]  ref_mem [MEM_BYTES];  // byte model of the 16 KiB memory
  logic [15:0] lfsr_q;

  riscv_data_cache dut0 (
    .i_riscv_dcache_clk          (clk),
    .i_rst_n                     (rst_n),
    .i_riscv_dcache_cpu_wren     (cpu_wren),
    .i_riscv_dcache_cpu_rden     (cpu_rden),
    .i_riscv_dcache_store_src    (store_size),
    .i_riscv_dcache_phys_addr    (phys_addr),
    .i_riscv_dcache_cpu_data_in  (cpu_wdata),
    .o_riscv_dcache_cpu_data_out (cpu_rdata),
    .o_riscv_dcache_cpu_stall    (cpu_stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic int size_bytes(input dcache_pkg::store_size_e sz);
    case (sz)
      dcache_pkg::SZ_BYTE: return 1;
      dcache_pkg::SZ_HALF: return 2;
      dcache_pkg::SZ_WORD: return 4;
      default:             return 8;
    endcase
  endfunction

  // only the low bytes of the store data land in memory
  task automatic model_store(input logic [63:0] addr, input logic [63:0] data,
                             input dcache_pkg::store_size_e sz);
    logic [13:0] a;
    a = addr[13:0];  // upper address bits alias
    for (int i = 0; i < size_bytes(sz); i++) begin
      ref_mem[a + 14'(i)] = data[i*8 +: 8];
    end
  endtask

  function automatic logic [63:0] model_load(input logic [63:0] addr);
    logic [63:0] r;
    logic [13:0] a;
    a = {addr[13:3], 3'b000};  // doubleword holding the address
    r = '0;
    for (int i = 0; i < 8; i++) begin
      r[i*8 +: 8] = ref_mem[a + 14'(i)];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // core side requests
  //////////////////////////////////////////////////////////////////////

  // stall is polled mid-cycle, ahead of the next rising edge
  task automatic wait_for_no_stall(output logic first_stall);
    int cycles;
    cycles = 0;
    #1;
    first_stall = cpu_stall;
    while (cpu_stall !== 1'b0) begin
      if (cycles >= STALL_LIMIT) begin
        abort_run("stall timeout: the cache never released the request");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic do_load(input logic [63:0] addr, output logic [63:0] data,
                         output logic stalled);
    @(negedge clk);
    phys_addr = addr;
    cpu_rden  = 1'b1;
    wait_for_no_stall(stalled);
    data = cpu_rdata;  // held until the completing edge
    @(posedge clk);
    @(negedge clk);
    cpu_rden = 1'b0;
  endtask

  task automatic do_store(input logic [63:0] addr, input logic [63:0] data,
                          input dcache_pkg::store_size_e sz, output logic stalled);
    @(negedge clk);
    phys_addr  = addr;
    cpu_wdata  = data;
    store_size = sz;
    cpu_wren   = 1'b1;
    wait_for_no_stall(stalled);
    @(posedge clk);  // store lands here
    model_store(addr, data, sz);
    @(negedge clk);
    cpu_wren = 1'b0;
  endtask

  task automatic load_check(input logic [63:0] addr);
    logic [63:0] data;
    logic        stalled;
    do_load(addr, data, stalled);
    check_data("o_riscv_dcache_cpu_data_out", model_load(addr), data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [63:0] data;
    logic        stalled;
    check_bit("o_riscv_dcache_cpu_stall", 1'b0, cpu_stall);
    do_load(64'h100, data, stalled);
    check_bit("o_riscv_dcache_cpu_stall", 1'b1, stalled);  // cold miss
    check_data("o_riscv_dcache_cpu_data_out", 64'h0, data);
    do_load(64'h100, data, stalled);
    check_bit("o_riscv_dcache_cpu_stall", 1'b0, stalled);
    check_data("o_riscv_dcache_cpu_data_out", 64'h0, data);
  endtask

  task automatic test_double_round_trip();
    logic [63:0] base;
    logic [63:0] w0;
    logic [63:0] w1;
    logic [63:0] data;
    logic        stalled;
    for (int k = 0; k < 4; k++) begin
      base = 64'h200 + 64'(k * 16);
      w0   = rand_bits(64);
      w1   = rand_bits(64);
      do_store(base, w0, dcache_pkg::SZ_DOUBLE, stalled);
      do_store(base + 64'h8, w1, dcache_pkg::SZ_DOUBLE, stalled);
      check_bit("o_riscv_dcache_cpu_stall", 1'b0, stalled);
      do_load(base, data, stalled);
      check_data("o_riscv_dcache_cpu_data_out", w0, data);
      do_load(base + 64'h8, data, stalled);
      check_bit("o_riscv_dcache_cpu_stall", 1'b0, stalled);
      check_data("o_riscv_dcache_cpu_data_out", w1, data);
    end
  endtask

  // upper bits of each store carry junk that must not land
  task automatic test_store_sizes();
    logic [63:0] base;
    logic        stalled;
    base = 64'h3a0;
    do_store(base, 64'h1122_3344_5566_7788, dcache_pkg::SZ_DOUBLE, stalled);
    do_store(base + 64'h1, 64'hffff_ffff_ffff_ffab, dcache_pkg::SZ_BYTE, stalled);
    do_store(base + 64'h6, 64'h9999_9999_9999_cdef, dcache_pkg::SZ_HALF, stalled);
    load_check(base);
    do_store(base + 64'h8, 64'h0123_4567_89ab_cdef, dcache_pkg::SZ_DOUBLE, stalled);
    do_store(base + 64'h8, 64'h7777_7777_dead_beef, dcache_pkg::SZ_WORD, stalled);
    do_store(base + 64'hf, 64'h0000_0000_0000_005a, dcache_pkg::SZ_BYTE, stalled);
    load_check(base + 64'h8);
  endtask

  task automatic test_dirty_eviction();
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] data;
    logic        stalled;
    wa = rand_bits(64);
    wb = rand_bits(64);
    do_store(64'h0c0, wa, dcache_pkg::SZ_DOUBLE, stalled);
    do_load(64'h4c8, data, stalled);  // same index, tag 1
    check_bit("o_riscv_dcache_cpu_stall", 1'b1, stalled);
    check_data("o_riscv_dcache_cpu_data_out", model_load(64'h4c8), data);
    do_store(64'h4c8, wb, dcache_pkg::SZ_DOUBLE, stalled);
    do_load(64'h0c0, data, stalled);
    check_bit("o_riscv_dcache_cpu_stall", 1'b1, stalled);
    check_data("o_riscv_dcache_cpu_data_out", wa, data);
    do_load(64'h4c8, data, stalled);
    check_data("o_riscv_dcache_cpu_data_out", wb, data);
  endtask

  task automatic test_lfsr_mix();
    logic [63:0]             addr;
    logic [63:0]             sz_bits;
    logic [63:0]             op_bit;
    dcache_pkg::store_size_e sz;
    logic                    stalled;
    for (int n = 0; n < 200; n++) begin
      addr    = rand_bits(11);  // 2 KiB window, two tags per index
      sz_bits = rand_bits(2);
      op_bit  = rand_bits(1);
      sz      = dcache_pkg::store_size_e'(sz_bits[1:0]);
      addr    = addr & ~((64'h1 << sz) - 64'h1);  // natural alignment
      if (op_bit[0]) begin
        do_store(addr, rand_bits(64), sz, stalled);
      end else begin
        load_check(addr);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    cpu_wren   = 1'b0;
    cpu_rden   = 1'b0;
    store_size = dcache_pkg::SZ_DOUBLE;
    phys_addr  = '0;
    cpu_wdata  = '0;
    lfsr_q     = 16'd9;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_double_round_trip();
    test_store_sizes();
    test_dirty_eviction();
    test_lfsr_mix();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl_fsm.sv
rtl/dcache_backing_mem.sv
rtl/riscv_data_cache.sv
dv/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module tb_dcache -f project.f -o Vtb_dcache \
  && ./obj_dir/Vtb_dcache > sim.log 2>&1

# the log decides pass or fail
grep -q "ALL TESTS PASSED" sim.log \
  && echo "simulation passed, see sim.log" \
  || { echo "simulation failed, see sim.log"; exit 1; }
